// File: include/wbuf_consts.svh
// sizing constants for the coalescing write buffer
// included by both packages and by every module that sizes an array
`ifndef WBUF_CONSTS_SVH
`define WBUF_CONSTS_SVH

// number of buffer entries, each holds one data word
`define WBUF_DEPTH 8

// bytes per data word
// the transfer sizes byte, half, word and dword assume 8 here
`define WBUF_WORD_BYTES 8

// physical address width
`define WBUF_PADDR_W 32

// transaction slots towards memory
// also the depth of the returned-id FIFO
`define WBUF_MAX_TX 4

`endif

// File: rtl/wbuf_pkg.sv
// types for the write buffer entries and for the updates applied to them
// referenced by scoped name from the RTL and the testbench
`include "wbuf_consts.svh"

package wbuf_pkg;

  // word address, byte offset bits dropped
  typedef logic [`WBUF_PADDR_W-$clog2(`WBUF_WORD_BYTES)-1:0] wbuf_wtag_t;
  // one flag per byte of a word
  typedef logic [`WBUF_WORD_BYTES-1:0] wbuf_be_t;
  typedef logic [8*`WBUF_WORD_BYTES-1:0] wbuf_data_t;
  // entry index
  typedef logic [$clog2(`WBUF_DEPTH)-1:0] wbuf_ptr_t;

  // one buffer entry
  // legal byte states valid/dirty/txblock: 000, 110, 101, 111
  typedef struct packed {
    wbuf_wtag_t wtag;
    wbuf_data_t data;
    wbuf_be_t   valid;
    wbuf_be_t   dirty;
    wbuf_be_t   txblock;
  } wbuf_entry_t;

  // core store request, req held until granted
  typedef struct packed {
    logic       req;
    wbuf_wtag_t wtag;
    wbuf_be_t   be;
    wbuf_data_t data;
  } wbuf_store_t;

  // granted store, aimed at one entry
  typedef struct packed {
    logic       en;
    wbuf_ptr_t  ptr;
    wbuf_wtag_t wtag;
    wbuf_be_t   be;
    wbuf_data_t data;
  } wbuf_wr_t;

  // returned transfer, names the entry and the bytes it carried
  typedef struct packed {
    logic      en;
    wbuf_ptr_t ptr;
    wbuf_be_t  be;
  } wbuf_evict_t;

endpackage

// File: rtl/mem_pkg.sv
// types for the memory side of the write buffer
// outgoing transfer, its size encoding and the transaction id
`include "wbuf_consts.svh"

package mem_pkg;

  // transfer size, aligned to itself
  typedef enum logic [1:0] {
    size_byte  = 2'd0,
    size_half  = 2'd1,
    size_word  = 2'd2,
    size_dword = 2'd3
  } mem_size_e;

  // transaction slot number
  typedef logic [$clog2(`WBUF_MAX_TX)-1:0] mem_tid_t;

  // outgoing write, data replicated over the whole word
  typedef struct packed {
    logic [`WBUF_PADDR_W-1:0] paddr;
    mem_size_e                size;
    mem_tid_t                 tid;
    wbuf_pkg::wbuf_data_t     wdata;
  } mem_tx_t;

  // accepted transfer as seen by the buffer
  // fire marks the req and ack cycle
  typedef struct packed {
    logic                fire;
    wbuf_pkg::wbuf_ptr_t ptr;
    wbuf_pkg::wbuf_be_t  be;
  } mem_issue_t;

endpackage

// File: rtl/wbuf_alloc.sv
// entry allocation for core stores
// a store merges into the entry holding its word, or takes the lowest free entry
// grant is combinational in the request cycle
`include "wbuf_consts.svh"

module wbuf_alloc (
  input  wbuf_pkg::wbuf_entry_t [`WBUF_DEPTH-1:0] entries_i,
  input  wbuf_pkg::wbuf_store_t                   store_i,
  output logic                                    store_gnt_o,
  output wbuf_pkg::wbuf_wr_t                      wr_o
);

  logic [`WBUF_DEPTH-1:0] hit;
  logic [`WBUF_DEPTH-1:0] free;
  wbuf_pkg::wbuf_ptr_t    hit_ptr;
  wbuf_pkg::wbuf_ptr_t    free_ptr;

  for (genvar k = 0; k < `WBUF_DEPTH; k++) begin : gen_cmp
    // stale tags of empty entries never match
    assign hit[k]  = (|entries_i[k].valid) && (entries_i[k].wtag == store_i.wtag);
    assign free[k] = ~|entries_i[k].valid;
  end

  always_comb begin : p_find
    hit_ptr  = '0;
    free_ptr = '0;
    // scan downwards so the lowest index is left standing
    for (int k = `WBUF_DEPTH - 1; k >= 0; k--) begin
      if (hit[k]) begin
        hit_ptr = wbuf_pkg::wbuf_ptr_t'(k);
      end
      if (free[k]) begin
        free_ptr = wbuf_pkg::wbuf_ptr_t'(k);
      end
    end
  end

  // full buffer only takes stores to words it already holds
  assign store_gnt_o = store_i.req && ((|hit) || (|free));

  assign wr_o.en   = store_gnt_o;
  assign wr_o.ptr  = (|hit) ? hit_ptr : free_ptr;
  assign wr_o.wtag = store_i.wtag;
  assign wr_o.be   = store_i.be;
  assign wr_o.data = store_i.data;

endmodule

// File: rtl/wbuf_tx_issue.sv
// selection of the next dirty entry and forming of its memory transfer
// entries are served round-robin, one aligned chunk of dirty bytes at a time
// miss_req_o is a level and stays up until miss_ack_i
`include "wbuf_consts.svh"

module wbuf_tx_issue (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  wbuf_pkg::wbuf_entry_t [`WBUF_DEPTH-1:0] entries_i,
  input  logic                                    tx_free_i,
  input  mem_pkg::mem_tid_t                       tx_tid_i,
  input  logic                                    miss_ack_i,
  output logic                                    miss_req_o,
  output mem_pkg::mem_tx_t                        miss_o,
  output mem_pkg::mem_issue_t                     issue_o
);

  localparam int OFF_W = $clog2(`WBUF_WORD_BYTES);

  wbuf_pkg::wbuf_be_t [`WBUF_DEPTH-1:0] sendable;
  logic [`WBUF_DEPTH-1:0]               has_send;
  wbuf_pkg::wbuf_ptr_t                  rr_q;
  wbuf_pkg::wbuf_ptr_t                  arb_ptr;
  wbuf_pkg::wbuf_ptr_t                  lock_ptr_q;
  wbuf_pkg::wbuf_ptr_t                  sel_ptr;
  logic                                 lock_q;
  logic                                 fire;
  wbuf_pkg::wbuf_be_t                   sel_be;
  wbuf_pkg::wbuf_be_t                   tx_be;
  wbuf_pkg::wbuf_data_t                 sel_data;
  wbuf_pkg::wbuf_data_t                 rep_data;
  logic [OFF_W-1:0]                     off;
  logic [OFF_W-1:0]                     size_mask;
  mem_pkg::mem_size_e                   size;

  //////////////////////////////////////////////////////////////////////
  // entry selection
  //////////////////////////////////////////////////////////////////////

  // a word with bytes in flight is held back until its response
  // two writes to one word could otherwise overtake each other
  for (genvar k = 0; k < `WBUF_DEPTH; k++) begin : gen_send
    assign sendable[k] = (|entries_i[k].txblock) ? '0 :
                         (entries_i[k].dirty & entries_i[k].valid);
    assign has_send[k] = |sendable[k];
  end

  // first sendable entry at or after the round-robin pointer
  always_comb begin : p_arb
    wbuf_pkg::wbuf_ptr_t idx;
    logic                found;
    arb_ptr = rr_q;
    found   = 1'b0;
    for (int i = 0; i < `WBUF_DEPTH; i++) begin
      // index wraps in the pointer width
      idx = rr_q + wbuf_pkg::wbuf_ptr_t'(i);
      if (!found && has_send[idx]) begin
        found   = 1'b1;
        arb_ptr = idx;
      end
    end
  end

  // choice is locked while the request waits for its ack
  assign sel_ptr  = lock_q ? lock_ptr_q : arb_ptr;
  assign sel_be   = sendable[sel_ptr];
  assign sel_data = entries_i[sel_ptr].data;

  //////////////////////////////////////////////////////////////////////
  // aligned transfer
  //////////////////////////////////////////////////////////////////////

  // lowest sendable byte
  always_comb begin : p_offset
    off = '0;
    for (int k = `WBUF_WORD_BYTES - 1; k >= 0; k--) begin
      if (sel_be[k]) begin
        off = OFF_W'(k);
      end
    end
  end

  // largest aligned size fully covered by sendable bytes
  // gaps in the mask split the word into several transfers
  always_comb begin : p_size
    wbuf_pkg::wbuf_be_t m4;
    wbuf_pkg::wbuf_be_t m2;
    m4 = 8'h0f << off;
    m2 = 8'h03 << off;
    if (&sel_be) begin
      size      = mem_pkg::size_dword;
      size_mask = 3'd7;
      tx_be     = '1;
    end else if ((off[1:0] == 2'b00) && ((sel_be & m4) == m4)) begin
      size      = mem_pkg::size_word;
      size_mask = 3'd3;
      tx_be     = m4;
    end else if (!off[0] && ((sel_be & m2) == m2)) begin
      size      = mem_pkg::size_half;
      size_mask = 3'd1;
      tx_be     = m2;
    end else begin
      size      = mem_pkg::size_byte;
      size_mask = 3'd0;
      tx_be     = 8'h01 << off;
    end
  end

  // replicate the addressed chunk over the word
  // offset is aligned, so or-ing in the low lane bits walks the chunk
  always_comb begin : p_rep
    for (int j = 0; j < `WBUF_WORD_BYTES; j++) begin
      rep_data[j*8+:8] = sel_data[(off | (OFF_W'(j) & size_mask))*8+:8];
    end
  end

  assign miss_req_o   = (|has_send) && tx_free_i;
  assign fire         = miss_req_o && miss_ack_i;

  assign miss_o.paddr = {entries_i[sel_ptr].wtag, off};
  assign miss_o.size  = size;
  assign miss_o.tid   = tx_tid_i;
  assign miss_o.wdata = rep_data;

  assign issue_o.fire = fire;
  assign issue_o.ptr  = sel_ptr;
  assign issue_o.be   = tx_be;

  // pointer moves past an entry only once it has fired
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr
    if (!rst_ni) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
    end else begin
      if (fire) begin
        rr_q   <= sel_ptr + 1'b1;
        lock_q <= 1'b0;
      end else if (miss_req_o) begin
        lock_q <= 1'b1;
      end
    end
  end

  // remember the entry of a pending request
  always_ff @(posedge clk_i) begin : p_lock_ptr
    if (miss_req_o && !lock_q) begin
      lock_ptr_q <= arb_ptr;
    end
  end

endmodule

// File: rtl/wbuf_tx_tracker.sv
// transaction slot table for transfers in flight
// returned ids queue in a small FIFO, each pop evicts the slot's bytes
// the lowest free slot is offered for the next transfer
`include "wbuf_consts.svh"

module wbuf_tx_tracker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  mem_pkg::mem_issue_t   issue_i,
  input  logic                  rtrn_vld_i,
  input  mem_pkg::mem_tid_t     rtrn_tid_i,
  output logic                  tx_free_o,
  output mem_pkg::mem_tid_t     tx_tid_o,
  output wbuf_pkg::wbuf_evict_t evict_o
);

  localparam int CNT_W = $clog2(`WBUF_MAX_TX + 1);

  // slot table
  logic [`WBUF_MAX_TX-1:0] slot_vld_q;
  wbuf_pkg::wbuf_ptr_t     slot_ptr_q [`WBUF_MAX_TX];
  wbuf_pkg::wbuf_be_t      slot_be_q  [`WBUF_MAX_TX];

  // returned-id FIFO
  mem_pkg::mem_tid_t fifo_q [`WBUF_MAX_TX];
  mem_pkg::mem_tid_t wr_idx_q;
  mem_pkg::mem_tid_t rd_idx_q;
  mem_pkg::mem_tid_t rtrn_tid;
  logic [CNT_W-1:0]  cnt_q;
  logic              pop;

  //////////////////////////////////////////////////////////////////////
  // slot allocation
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_free
    tx_tid_o = '0;
    for (int k = `WBUF_MAX_TX - 1; k >= 0; k--) begin
      if (!slot_vld_q[k]) begin
        tx_tid_o = mem_pkg::mem_tid_t'(k);
      end
    end
  end

  assign tx_free_o = ~&slot_vld_q;

  //////////////////////////////////////////////////////////////////////
  // response queue
  //////////////////////////////////////////////////////////////////////

  // not fall-through, a pushed id shows up one cycle later
  // at most one id per slot can be queued, so the FIFO never overflows
  assign pop      = (cnt_q != '0);
  assign rtrn_tid = fifo_q[rd_idx_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_fifo_ctrl
    if (!rst_ni) begin
      wr_idx_q <= '0;
      rd_idx_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (rtrn_vld_i) begin
        wr_idx_q <= wr_idx_q + 1'b1;
      end
      if (pop) begin
        rd_idx_q <= rd_idx_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(rtrn_vld_i) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin : p_fifo_mem
    if (rtrn_vld_i) begin
      fifo_q[wr_idx_q] <= rtrn_tid_i;
    end
  end

  // eviction completes in the pop cycle
  assign evict_o.en  = pop;
  assign evict_o.ptr = slot_ptr_q[rtrn_tid];
  assign evict_o.be  = slot_be_q[rtrn_tid];

  // popped slot frees next cycle
  // offered id is free, so it never equals the popped one
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_slot_vld
    if (!rst_ni) begin
      slot_vld_q <= '0;
    end else begin
      if (pop) begin
        slot_vld_q[rtrn_tid] <= 1'b0;
      end
      if (issue_i.fire) begin
        slot_vld_q[tx_tid_o] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_slot_data
    if (issue_i.fire) begin
      slot_ptr_q[tx_tid_o] <= issue_i.ptr;
      slot_be_q[tx_tid_o]  <= issue_i.be;
    end
  end

endmodule

// File: rtl/wbuf_entries.sv
// entry register array of the write buffer
// eviction, issue and store updates merge into one next state, in that order
// byte flags are reset, word address and data are not
`include "wbuf_consts.svh"

module wbuf_entries (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  wbuf_pkg::wbuf_wr_t                      wr_i,
  input  mem_pkg::mem_issue_t                     issue_i,
  input  wbuf_pkg::wbuf_evict_t                   evict_i,
  output wbuf_pkg::wbuf_entry_t [`WBUF_DEPTH-1:0] entries_o,
  output logic                                    empty_o
);

  wbuf_pkg::wbuf_wtag_t                 wtag_q [`WBUF_DEPTH];
  wbuf_pkg::wbuf_data_t                 data_q [`WBUF_DEPTH];
  wbuf_pkg::wbuf_be_t [`WBUF_DEPTH-1:0] valid_q;
  wbuf_pkg::wbuf_be_t [`WBUF_DEPTH-1:0] valid_d;
  wbuf_pkg::wbuf_be_t [`WBUF_DEPTH-1:0] dirty_q;
  wbuf_pkg::wbuf_be_t [`WBUF_DEPTH-1:0] dirty_d;
  wbuf_pkg::wbuf_be_t [`WBUF_DEPTH-1:0] txblock_q;
  wbuf_pkg::wbuf_be_t [`WBUF_DEPTH-1:0] txblock_d;

  //////////////////////////////////////////////////////////////////////
  // byte state update
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_next
    valid_d   = valid_q;
    dirty_d   = dirty_q;
    txblock_d = txblock_q;

    // response: unblock the bytes, drop those not rewritten in flight
    // rewritten bytes stay 1/1/0 and are sent again
    if (evict_i.en) begin
      txblock_d[evict_i.ptr] = txblock_q[evict_i.ptr] & ~evict_i.be;
      valid_d[evict_i.ptr]   = valid_q[evict_i.ptr] & ~(evict_i.be & ~dirty_q[evict_i.ptr]);
    end

    // accepted transfer: dirty bytes move to in flight
    // never the evicted entry, an entry with txblock bits is not sent
    if (issue_i.fire) begin
      dirty_d[issue_i.ptr]   = dirty_d[issue_i.ptr] & ~issue_i.be;
      txblock_d[issue_i.ptr] = txblock_d[issue_i.ptr] | issue_i.be;
    end

    // store last, so a byte written during its own send ends 1/1/1
    if (wr_i.en) begin
      valid_d[wr_i.ptr] = valid_d[wr_i.ptr] | wr_i.be;
      dirty_d[wr_i.ptr] = dirty_d[wr_i.ptr] | wr_i.be;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_flags
    if (!rst_ni) begin
      valid_q   <= '0;
      dirty_q   <= '0;
      txblock_q <= '0;
    end else begin
      valid_q   <= valid_d;
      dirty_q   <= dirty_d;
      txblock_q <= txblock_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // word address and data
  //////////////////////////////////////////////////////////////////////

  // byte-wise merge of the store data
  always_ff @(posedge clk_i) begin : p_payload
    if (wr_i.en) begin
      wtag_q[wr_i.ptr] <= wr_i.wtag;
      for (int b = 0; b < `WBUF_WORD_BYTES; b++) begin
        if (wr_i.be[b]) begin
          data_q[wr_i.ptr][b*8+:8] <= wr_i.data[b*8+:8];
        end
      end
    end
  end

  for (genvar k = 0; k < `WBUF_DEPTH; k++) begin : gen_out
    assign entries_o[k].wtag    = wtag_q[k];
    assign entries_o[k].data    = data_q[k];
    assign entries_o[k].valid   = valid_q[k];
    assign entries_o[k].dirty   = dirty_q[k];
    assign entries_o[k].txblock = txblock_q[k];
  end

  // no valid byte anywhere
  assign empty_o = ~|valid_q;

endmodule

// File: rtl/wbuf_top.sv
// coalescing write buffer for a write-through data cache
// core stores in through store_i, aligned writes out through miss_o
// numbered write responses come back on rtrn_vld_i and rtrn_tid_i
`include "wbuf_consts.svh"

module wbuf_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // core store port
  input  wbuf_pkg::wbuf_store_t store_i,
  output logic                  store_gnt_o,
  // memory request port
  output logic                  miss_req_o,
  output mem_pkg::mem_tx_t      miss_o,
  input  logic                  miss_ack_i,
  // memory write responses
  input  logic                  rtrn_vld_i,
  input  mem_pkg::mem_tid_t     rtrn_tid_i,
  output logic                  empty_o
);

  wbuf_pkg::wbuf_entry_t [`WBUF_DEPTH-1:0] entries;
  wbuf_pkg::wbuf_wr_t                      wr;
  mem_pkg::mem_issue_t                     issue;
  wbuf_pkg::wbuf_evict_t                   evict;
  logic                                    tx_free;
  mem_pkg::mem_tid_t                       tx_tid;

  // store side
  wbuf_alloc i_alloc (
    .entries_i   (entries),
    .store_i     (store_i),
    .store_gnt_o (store_gnt_o),
    .wr_o        (wr)
  );

  // send side, works next to allocation on the same entry state
  wbuf_tx_issue i_tx_issue (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .entries_i  (entries),
    .tx_free_i  (tx_free),
    .tx_tid_i   (tx_tid),
    .miss_ack_i (miss_ack_i),
    .miss_req_o (miss_req_o),
    .miss_o     (miss_o),
    .issue_o    (issue)
  );

  // transfers in flight and their responses
  wbuf_tx_tracker i_tx_tracker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .issue_i    (issue),
    .rtrn_vld_i (rtrn_vld_i),
    .rtrn_tid_i (rtrn_tid_i),
    .tx_free_o  (tx_free),
    .tx_tid_o   (tx_tid),
    .evict_o    (evict)
  );

  wbuf_entries i_entries (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_i      (wr),
    .issue_i   (issue),
    .evict_i   (evict),
    .entries_o (entries),
    .empty_o   (empty_o)
  );

endmodule

// File: dv/wbuf_sva.sv
// concurrent assertions for the write buffer
// bound into wbuf_entries for byte states and into wbuf_tx_tracker for slots
`include "wbuf_consts.svh"

module wbuf_sva (
  input logic                                          clk_i,
  input logic                                          rst_ni,
  input logic [`WBUF_DEPTH*`WBUF_WORD_BYTES-1:0]       valid_i,
  input logic [`WBUF_DEPTH*`WBUF_WORD_BYTES-1:0]       dirty_i,
  input logic [`WBUF_DEPTH*`WBUF_WORD_BYTES-1:0]       txblock_i,
  input logic [`WBUF_MAX_TX-1:0]                       slot_vld_i,
  input logic                                          pop_i,
  input logic                                          fire_i,
  input mem_pkg::mem_tid_t                             rtrn_tid_i,
  input mem_pkg::mem_tid_t                             tx_tid_i
);

  // an invalid byte carries no other flag
  a_invalid_clean: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (~valid_i & (dirty_i | txblock_i)) == '0)
    else $error("invalid byte with dirty or txblock set");

  // state 1/0/0 does not exist, a clean valid byte is always in flight
  a_valid_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_i & ~dirty_i & ~txblock_i) == '0)
    else $error("valid byte neither dirty nor in flight");

  a_no_reuse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pop_i && fire_i) |-> (rtrn_tid_i != tx_tid_i))
    else $error("slot freed and allocated in one cycle");

  a_evict_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> slot_vld_i[rtrn_tid_i])
    else $error("eviction of an unused slot");

endmodule

// byte states, slot ports tied off
bind wbuf_entries wbuf_sva i_sva_entries (
  .clk_i, .rst_ni,
  .valid_i (valid_q), .dirty_i (dirty_q), .txblock_i (txblock_q),
  .slot_vld_i ('0), .pop_i (1'b0), .fire_i (1'b0),
  .rtrn_tid_i ('0), .tx_tid_i ('0)
);

// slot use, byte ports tied off
bind wbuf_tx_tracker wbuf_sva i_sva_tracker (
  .clk_i, .rst_ni,
  .valid_i ('0), .dirty_i ('0), .txblock_i ('0),
  .slot_vld_i (slot_vld_q), .pop_i (pop), .fire_i (issue_i.fire),
  .rtrn_tid_i (rtrn_tid), .tx_tid_i (tx_tid_o)
);

// File: dv/wbuf_checker.sv
// reference model and comparisons for the write buffer
// watches the DUT ports, keeps last written bytes, a memory image and slot use
// samples on the falling edge where all ports are stable
`include "wbuf_consts.svh"

module wbuf_checker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  wbuf_pkg::wbuf_store_t store_i,
  input  logic                  store_gnt_i,
  input  logic                  miss_req_i,
  input  logic                  miss_ack_i,
  input  mem_pkg::mem_tx_t      miss_i,
  input  logic                  rtrn_vld_i,
  input  mem_pkg::mem_tid_t     rtrn_tid_i,
  output int                    err_cnt_o
);

  // byte address keyed
  logic [7:0] last_q [logic [31:0]];
  logic [7:0] mem_q  [logic [31:0]];
  logic       pend_q [logic [31:0]];

  // slots in flight and the responses that free them two cycles later
  logic [`WBUF_MAX_TX-1:0] busy_q = '0;
  logic [`WBUF_MAX_TX-1:0] rel1_q = '0;
  logic [`WBUF_MAX_TX-1:0] rel2_q = '0;

  initial err_cnt_o = 0;

  task automatic check_transfer();
    int          n;
    int          exp_tid;
    logic [31:0] a;
    logic [31:0] wbase;
    logic [63:0] exp_data;
    n        = 1 << miss_i.size;
    wbase    = {miss_i.paddr[31:3], 3'b000};
    exp_data = '0;
    exp_tid  = -1;
    if ((miss_i.paddr % n) != 0) begin
      $display("error %0t: address %h not aligned to %0d bytes", $time, miss_i.paddr, n);
      err_cnt_o++;
    end
    // a transfer takes the lowest slot not in flight
    for (int s = `WBUF_MAX_TX - 1; s >= 0; s--) begin
      if (!busy_q[s]) begin
        exp_tid = s;
      end
    end
    if (exp_tid < 0) begin
      $display("error %0t: transfer accepted with every slot in flight", $time);
      err_cnt_o++;
    end else if (miss_i.tid != exp_tid) begin
      $display("error %0t: tid %0d, expected %0d", $time, miss_i.tid, exp_tid);
      err_cnt_o++;
    end
    busy_q[miss_i.tid] = 1'b1;
    // lane j of the word carries byte j modulo the size
    for (int j = 0; j < 8; j++) begin
      a = miss_i.paddr + (j % n);
      if (last_q.exists(a)) exp_data[j*8+:8] = last_q[a];
    end
    if (miss_i.wdata !== exp_data) begin
      $display("error %0t: wdata %h, expected %h", $time, miss_i.wdata, exp_data);
      err_cnt_o++;
    end
    for (int j = 0; j < n; j++) begin
      a = miss_i.paddr + j;
      if (!pend_q.exists(a) || !pend_q[a]) begin
        $display("error %0t: byte %h sent without a pending write", $time, a);
        err_cnt_o++;
      end
      pend_q[a] = 1'b0;
      mem_q[a]  = miss_i.wdata[(a - wbase)*8+:8];
    end
  endtask

  task automatic record_store();
    logic [31:0] a;
    for (int b = 0; b < 8; b++) begin
      if (store_i.be[b]) begin
        a         = {store_i.wtag, 3'b000} + b;
        last_q[a] = store_i.data[b*8+:8];
        pend_q[a] = 1'b1;
      end
    end
  endtask

  // memory image against the last written value of every byte
  task automatic compare_memory();
    foreach (last_q[a]) begin
      if (!mem_q.exists(a) || mem_q[a] !== last_q[a]) begin
        $display("error %0t: memory byte %h wrong, expected %h", $time, a, last_q[a]);
        err_cnt_o++;
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (rst_ni) begin
      // a returned slot is offered again two cycles after its response pulse
      busy_q = busy_q & ~rel2_q;
      rel2_q = rel1_q;
      rel1_q = '0;
      if (rtrn_vld_i) begin
        rel1_q[rtrn_tid_i] = 1'b1;
      end
      // a store in the same cycle is not part of the transfer, so it is recorded after it
      if (miss_req_i && miss_ack_i) check_transfer();
      if (store_i.req && store_gnt_i) record_store();
    end
  end

endmodule

// File: dv/wbuf_tb.sv
// testbench for the coalescing write buffer
// applies a table of stores, answers transfers like a memory
// and checks grants, drain and the final memory image
`include "wbuf_consts.svh"

module wbuf_tb;

  localparam int NROWS = 20;

  logic                  clk_i = 1'b0;
  logic                  rst_ni = 1'b0;
  wbuf_pkg::wbuf_store_t store_i = '0;
  logic                  store_gnt_o;
  logic                  miss_req_o;
  mem_pkg::mem_tx_t      miss_o;
  logic                  miss_ack_i = 1'b0;
  logic                  rtrn_vld_i = 1'b0;
  mem_pkg::mem_tid_t     rtrn_tid_i = '0;
  logic                  empty_o;

  // stimulus table
  logic [28:0] t_wtag [NROWS];
  logic [7:0]  t_be   [NROWS];
  logic [63:0] t_data [NROWS];
  logic        t_ack  [NROWS];
  logic        t_gnt  [NROWS];

  integer            seed = 56534;
  logic              ack_en = 1'b0;
  int                cyc = 0;
  int                tb_err = 0;
  int                chk_err;
  int                n_fail = 0;
  mem_pkg::mem_tid_t ret_tid [$];
  int                ret_due [$];

  always #20 clk_i = ~clk_i;

  wbuf_top i_dut (.*);

  wbuf_checker i_chk (
    .clk_i, .rst_ni, .store_i,
    .store_gnt_i (store_gnt_o),
    .miss_req_i  (miss_req_o),
    .miss_ack_i  (miss_ack_i),
    .miss_i      (miss_o),
    .rtrn_vld_i  (rtrn_vld_i),
    .rtrn_tid_i  (rtrn_tid_i),
    .err_cnt_o   (chk_err)
  );

  function automatic void set_row(int r, logic [28:0] w, logic [7:0] be, logic ack, logic gnt);
    t_wtag[r] = w;
    t_be[r]   = be;
    t_data[r] = 64'h0123_4567_89ab_cdef ^ {8{8'(r * 37 + 5)}};
    t_ack[r]  = ack;
    t_gnt[r]  = gnt;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // memory side
  ////////////////////////////////////////////////////////////////////

  // random ack with at most one response pulse per cycle
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    #5;
    miss_ack_i = ack_en && ($random(seed) & 1);
    rtrn_vld_i = 1'b0;
    for (int i = 0; i < ret_due.size(); i++) begin
      if (ret_due[i] <= cyc) begin
        rtrn_vld_i = 1'b1;
        rtrn_tid_i = ret_tid[i];
        ret_tid.delete(i);
        ret_due.delete(i);
        break;
      end
    end
  end

  // accepted transfer comes back after 1 to 6 cycles
  always @(negedge clk_i) begin
    if (rst_ni && miss_req_o && miss_ack_i) begin
      ret_tid.push_back(miss_o.tid);
      ret_due.push_back(cyc + 1 + (($random(seed) & 32'h7fff_ffff) % 6));
    end
  end

  // watchdog
  initial begin
    repeat (NROWS * 50) @(posedge clk_i);
    $display("timeout: buffer did not finish the table and drain in time");
    $display("SIMULATION FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    int errs_before;
    int waited;
    // eight words with ack held low, then a ninth that must wait
    for (int k = 0; k < 8; k++) begin
      set_row(k, 29'h40 + k, 8'(8'hff >> k) | 8'(8'h81 << k), 1'b0, 1'b1);
    end
    set_row(8, 29'h48, 8'hff, 1'b0, 1'b0);
    set_row(9, 29'h42, 8'h03, 1'b0, 1'b1);
    // with ack on, rewrites land on words that may be in flight
    set_row(10, 29'h48, 8'hff, 1'b1, 1'b1);
    set_row(11, 29'h40, 8'h0f, 1'b1, 1'b1);
    set_row(12, 29'h40, 8'hf0, 1'b1, 1'b1);
    set_row(13, 29'h41, 8'hff, 1'b1, 1'b1);
    set_row(14, 29'h44, 8'h18, 1'b1, 1'b1);
    set_row(15, 29'h40, 8'h0f, 1'b1, 1'b1);
    set_row(16, 29'h49, 8'h55, 1'b1, 1'b1);
    set_row(17, 29'h42, 8'hff, 1'b1, 1'b1);
    set_row(18, 29'h4a, 8'h01, 1'b1, 1'b1);
    set_row(19, 29'h40, 8'hff, 1'b1, 1'b1);

    repeat (3) @(posedge clk_i);
    #5 rst_ni = 1'b1;

    for (int r = 0; r < NROWS; r++) begin
      errs_before = tb_err + chk_err;
      @(posedge clk_i);
      #5;
      // the memory side picks up a new ack setting from the next cycle on
      ack_en       <= t_ack[r];
      store_i.req  = 1'b1;
      store_i.wtag = t_wtag[r];
      store_i.be   = t_be[r];
      store_i.data = t_data[r];
      waited       = 0;
      // wait for the grant, or confirm a withheld one for a few cycles
      forever begin
        @(negedge clk_i);
        if (store_gnt_o) begin
          if (!t_gnt[r]) begin
            $display("error %0t: row %0d granted on a full buffer", $time, r);
            tb_err++;
          end
          break;
        end
        waited++;
        if (!t_gnt[r] && waited == 4) break;
      end
      if (!t_gnt[r]) begin
        @(posedge clk_i);
        #5 store_i.req = 1'b0;
      end
      if (tb_err + chk_err != errs_before) n_fail++;
      $display("test %0d: store to word %h %s", r, t_wtag[r],
               (tb_err + chk_err != errs_before) ? "failed" : "ok");
    end

    // drain
    errs_before = tb_err + chk_err;
    @(posedge clk_i);
    #5;
    store_i.req = 1'b0;
    ack_en      <= 1'b1;
    @(negedge clk_i);
    while (!empty_o) @(negedge clk_i);
    if (miss_req_o || ret_tid.size() != 0) begin
      $display("error %0t: buffer empty with requests or responses left", $time);
      tb_err++;
    end
    i_chk.compare_memory();
    if (tb_err + chk_err != errs_before) n_fail++;
    $display("test %0d: drain and final memory %s", NROWS,
             (tb_err + chk_err != errs_before) ? "failed" : "ok");

    $display("tests run %0d, failed %0d, errors %0d", NROWS + 1, n_fail, tb_err + chk_err);
    if (n_fail == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+include
rtl/wbuf_pkg.sv
rtl/mem_pkg.sv
rtl/wbuf_alloc.sv
rtl/wbuf_tx_issue.sv
rtl/wbuf_tx_tracker.sv
rtl/wbuf_entries.sv
rtl/wbuf_top.sv
dv/wbuf_sva.sv
dv/wbuf_checker.sv
dv/wbuf_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the write buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module wbuf_tb -o wbuf_sim

./obj_dir/wbuf_sim | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
  echo "run ended without a result line"
  exit 1
fi
echo "run passed"
